// File: files.f
+incdir+hw
+incdir+verif
hw/rv_pkg.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_core.sv
verif/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_pkg.sv
      - hw/rv_fetch.sv
      - hw/rv_decode.sv
      - hw/rv_execute.sv
      - hw/rv_result.sv
      - hw/rv_core.sv
  - target: test
    include_dirs:
      - hw
      - verif
    files:
      - verif/tb_rv_core.sv

// File: verif/tb_rv_asm.svh
`ifndef TB_RV_ASM_SVH
`define TB_RV_ASM_SVH

`include "rv_config.svh"

// Word built field by field through the R view
function automatic logic [31:0] r_view(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    rv_pkg::rv_instr_u w;
    w.r.funct7 = f7;
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = op;
    return w;
endfunction

// Same through the S view with imm12 already in S field order
function automatic logic [31:0] s_view(input logic [2:0] f3, input logic [6:0] op,
                                       input logic [4:0] rs1, input logic [4:0] rs2,
                                       input logic [11:0] imm12);
    rv_pkg::rv_instr_u w;
    w.s.imm_hi = imm12[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = f3;
    w.s.imm_lo = imm12[4:0];
    w.s.opcode = op;
    return w;
endfunction

function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return r_view(f7, rs2, rs1, f3, rd, `RV_OP_REG);
endfunction

function automatic logic [31:0] imm_op(input logic [6:0] op, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return r_view(imm[11:5], imm[4:0], rs1, f3, rd, op);
endfunction

function automatic logic [31:0] addi_op(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return imm_op(`RV_OP_IMM, 3'd0, rd, rs1, imm);
endfunction

function automatic logic [31:0] lw_op(input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return imm_op(`RV_OP_LOAD, 3'd2, rd, rs1, imm);
endfunction

function automatic logic [31:0] store_op(input logic [4:0] rs2, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return s_view(3'd2, `RV_OP_STORE, rs1, rs2, imm);   // SW
endfunction

// ne picks BNE and the offset is in bytes
function automatic logic [31:0] branch_op(input logic ne, input logic [4:0] rs1,
                                          input logic [4:0] rs2, input logic [12:0] off);
    return s_view({2'b00, ne}, `RV_OP_BRANCH, rs1, rs2,
                  {off[12], off[10:5], off[4:1], off[11]});
endfunction

function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
    return r_view(imm[19:13], imm[12:8], imm[7:3], imm[2:0], rd, `RV_OP_LUI);
endfunction

// Unsupported MISC-MEM word with a nonzero rd field, passes as a no-op
function automatic logic [31:0] nop_op(input logic [7:0] tag);
    return {tag, 12'b0, 5'd31, 7'b0001111};
endfunction

function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
endfunction

`endif

// File: verif/tb_rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rv_core;

    localparam int CLK_PERIOD = 20;
    localparam int SEED       = 83;
    localparam int PAD_WORDS  = 8;
    localparam int TEST_WORDS = 108;    // Words loaded over all tests with padding
    localparam int WATCH_NS   = TEST_WORDS * 40 * CLK_PERIOD;

    logic                   clk        = 1'b0;
    logic                   rst_n      = 1'b0;
    logic                   run        = 1'b0;
    logic                   imem_we    = 1'b0;
    logic [`RV_IMEM_AW-1:0] imem_addr  = '0;
    logic [`RV_XLEN-1:0]    imem_wdata = '0;
    logic                   wb_valid;
    logic [`RV_REG_AW-1:0]  wb_rd;
    logic [`RV_XLEN-1:0]    wb_data;

    logic [31:0] prog [$];
    logic [31:0] exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] model_regs [32] = '{default: '0};
    logic [31:0] model_mem [256];
    logic [31:0] rng_state = SEED;

    `include "tb_rv_asm.svh"

    rv_core i_dut (
        .clk, .rst_n, .run,
        .imem_we, .imem_addr, .imem_wdata,
        .wb_valid, .wb_rd, .wb_data
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCH_NS);
        $display("Timeout: the core stopped retiring instructions");
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns %s: expected %h, actual %h", $time, name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    // ISA model that walks the program and lists what should retire
    task automatic model_program();
        rv_pkg::rv_instr_u w;
        logic [31:0]       word;
        logic [31:0]       a;
        logic [31:0]       b;
        logic [31:0]       res;
        logic [31:0]       addr;
        bit                wr;
        int                pc;
        int                steps;
        exp_rd.delete();
        exp_data.delete();
        pc = 0;
        steps = 0;
        while (pc / 4 < prog.size() && steps < 1000) begin
            word = prog[pc / 4];
            w = word;
            a = model_regs[w.r.rs1];
            b = model_regs[w.r.rs2];
            wr = 1'b0;
            pc += 4;
            steps++;
            case (w.r.opcode)
                `RV_OP_LUI: begin
                    res = {word[31:12], 12'b0};
                    wr = 1'b1;
                end
                `RV_OP_IMM, `RV_OP_REG: begin
                    if (w.r.opcode == `RV_OP_IMM) begin
                        b = {{20{word[31]}}, word[31:20]};
                    end
                    case (w.r.funct3)
                        3'b000:  res = (w.r.opcode == `RV_OP_REG && word[30]) ? a - b : a + b;
                        3'b001:  res = a << b[4:0];
                        3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                        3'b100:  res = a ^ b;
                        3'b101:  res = a >> b[4:0];
                        3'b110:  res = a | b;
                        default: res = a & b;
                    endcase
                    wr = 1'b1;
                end
                `RV_OP_LOAD: begin
                    addr = a + {{20{word[31]}}, word[31:20]};
                    if (w.r.rd != 0) model_regs[w.r.rd] = model_mem[addr[9:2]];   // Off the trace
                end
                `RV_OP_STORE: begin
                    addr = a + {{20{word[31]}}, word[31:25], word[11:7]};
                    model_mem[addr[9:2]] = b;
                end
                `RV_OP_BRANCH: begin
                    if ((a == b) != word[12]) begin
                        pc = pc - 4 + {{19{word[31]}}, word[31], word[7], word[30:25],
                                       word[11:8], 1'b0};
                    end
                end
                default: ;
            endcase
            if (wr && w.r.rd != 0) begin
                model_regs[w.r.rd] = res;
                exp_rd.push_back(w.r.rd);
                exp_data.push_back(res);
            end
        end
    endtask

    // Halt, load, run, then compare the retire trace in order
    task automatic run_program();
        int got;
        model_program();
        @(posedge clk);
        run <= 1'b0;
        for (int i = 0; i < prog.size() + PAD_WORDS; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= 8'(i);
            if (i < prog.size()) imem_wdata <= prog[i];
            else imem_wdata <= nop_op(8'(i));
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;
        got = 0;
        while (got < exp_rd.size()) begin
            @(posedge clk);
            if (wb_valid) begin
                check_value("wb_rd", wb_rd, exp_rd[got]);
                check_value("wb_data", wb_data, exp_data[got]);
                got++;
            end
        end
        repeat (6) begin    // Tail of the program and padding stay quiet
            @(posedge clk);
            check_value("wb_valid", wb_valid, 32'd0);
        end
    endtask

    task automatic alu_ops();
        logic [31:0] r;
        logic [2:0]  reg_f3 [8] = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd4, 3'd5, 3'd6, 3'd7};
        logic [2:0]  imm_f3 [5] = '{3'd0, 3'd2, 3'd4, 3'd6, 3'd7};
        prog.delete();
        for (int i = 1; i <= 4; i++) begin
            r = lcg_next(rng_state);
            prog.push_back(lui_op(i, r[31:12]));
            prog.push_back(addi_op(i, i, r[11:0]));
        end
        for (int k = 0; k < 8; k++) begin   // ADD SUB SLL SLT XOR SRL OR AND
            prog.push_back(reg_op(k == 1 ? 7'h20 : 7'h00, reg_f3[k], 5 + k, 1 + k % 4,
                                  1 + (k + 1) % 4));
        end
        for (int k = 0; k < 5; k++) begin   // ADDI SLTI XORI ORI ANDI
            r = lcg_next(rng_state);
            prog.push_back(imm_op(`RV_OP_IMM, imm_f3[k], 13 + k, 1 + k % 4, r[11:0]));
        end
        run_program();
    endtask

    // rs1 from one back hits forwarding and rs2 from two back hits the bank bypass
    task automatic dependent_chain();
        logic [31:0] r;
        r = lcg_next(rng_state);
        prog.delete();
        prog.push_back(addi_op(18, 0, r[11:0]));
        prog.push_back(addi_op(19, 18, r[23:12]));
        for (int k = 0; k < 8; k++) begin   // ADD, SUB, XOR in turn
            prog.push_back(reg_op(k % 3 == 1 ? 7'h20 : 7'h00, k % 3 == 2 ? 3'd4 : 3'd0,
                                  20 + k, 19 + k, 18 + k));
        end
        run_program();
    endtask

    task automatic load_store();
        logic [31:0] r;
        r = lcg_next(rng_state);
        prog.delete();
        prog.push_back(addi_op(5, 0, 12'd64));     // Base address
        prog.push_back(lui_op(6, r[31:12]));
        prog.push_back(addi_op(6, 6, r[11:0]));
        prog.push_back(addi_op(7, 0, r[23:12]));
        prog.push_back(store_op(6, 5, 12'd0));
        prog.push_back(store_op(7, 5, 12'd4));
        prog.push_back(lw_op(8, 5, 12'd4));        // Word stored just before
        prog.push_back(reg_op(7'h00, 3'd0, 9, 8, 6));
        prog.push_back(lw_op(10, 5, 12'd0));
        prog.push_back(addi_op(11, 10, 12'd0));
        prog.push_back(store_op(9, 5, 12'hffc));   // Offset -4
        prog.push_back(lw_op(12, 5, 12'hffc));
        prog.push_back(reg_op(7'h00, 3'd4, 13, 12, 0));
        run_program();
    endtask

    task automatic branches();
        prog.delete();
        prog.push_back(addi_op(1, 0, 12'd7));
        prog.push_back(addi_op(2, 0, 12'd7));
        prog.push_back(addi_op(3, 0, 12'd9));
        prog.push_back(branch_op(1'b0, 1, 2, 13'd12));     // BEQ taken
        prog.push_back(addi_op(10, 0, 12'd1));
        prog.push_back(addi_op(11, 0, 12'd2));
        prog.push_back(addi_op(12, 0, 12'd3));
        prog.push_back(branch_op(1'b1, 1, 2, 13'd12));     // BNE not taken
        prog.push_back(addi_op(13, 0, 12'd4));
        prog.push_back(branch_op(1'b1, 1, 3, 13'd12));     // BNE taken
        prog.push_back(addi_op(14, 0, 12'd5));
        prog.push_back(addi_op(15, 0, 12'd6));
        prog.push_back(addi_op(16, 0, 12'd7));
        prog.push_back(branch_op(1'b0, 1, 3, 13'd8));      // BEQ not taken
        prog.push_back(addi_op(17, 1, 12'd8));
        run_program();
    endtask

    task automatic no_writeback();
        prog.delete();
        prog.push_back(addi_op(0, 0, 12'd123));
        prog.push_back(reg_op(7'h00, 3'd0, 0, 1, 2));
        prog.push_back(lui_op(0, 20'habcde));
        prog.push_back(store_op(1, 5, 12'd16));
        prog.push_back(branch_op(1'b1, 0, 0, 13'd16));     // Never taken
        prog.push_back(nop_op(8'h5a));
        prog.push_back(lw_op(0, 5, 12'd16));
        prog.push_back(reg_op(7'h00, 3'd6, 20, 0, 0));     // x0 must still read zero
        prog.push_back(addi_op(21, 0, 12'd5));
        run_program();
    endtask

    initial begin
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        alu_ops();
        dependent_chain();
        load_store();
        branches();
        no_writeback();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_wdata,
    output logic                   wb_valid,
    output logic [`RV_REG_AW-1:0]  wb_rd,
    output logic [`RV_XLEN-1:0]    wb_data
);

    // Fetch to decode
    logic                    f_valid;
    logic [`RV_XLEN-1:0]     f_pc;
    rv_pkg::rv_instr_u       f_instr;

    // Decode to execute
    logic                    d_valid;
    logic [`RV_XLEN-1:0]     d_pc;
    logic [`RV_REG_AW-1:0]   d_rs1;
    logic [`RV_REG_AW-1:0]   d_rs2;
    logic [`RV_XLEN-1:0]     d_rs1_data;
    logic [`RV_XLEN-1:0]     d_rs2_data;
    logic [`RV_XLEN-1:0]     d_imm;
    logic [`RV_REG_AW-1:0]   d_rd;
    logic [`RV_ALU_OP_W-1:0] d_alu_op;
    logic                    d_use_imm;
    logic                    d_mem_read;
    logic                    d_mem_write;
    logic                    d_branch;
    logic                    d_branch_ne;
    logic                    d_reg_write;

    // Execute to result
    logic                    e_valid;
    logic [`RV_REG_AW-1:0]   e_rd;
    logic [`RV_XLEN-1:0]     e_alu_result;
    logic                    e_mem_read;
    logic                    e_reg_write;
    logic [`RV_XLEN-1:0]     e_load_data;

    // Branch redirect and write-back
    logic                    redirect;
    logic [`RV_XLEN-1:0]     redirect_pc;
    logic                    r_write;
    logic [`RV_REG_AW-1:0]   r_rd;
    logic [`RV_XLEN-1:0]     r_data;

    rv_fetch i_fetch (
        .clk, .rst_n, .run,
        .imem_we, .imem_addr, .imem_wdata,
        .redirect, .redirect_pc,
        .f_valid, .f_pc, .f_instr
    );

    rv_decode i_decode (
        .clk, .rst_n, .run,
        .f_valid, .f_pc, .f_instr,
        .redirect,
        .r_write, .r_rd, .r_data,
        .d_valid, .d_pc, .d_rs1, .d_rs2, .d_rs1_data, .d_rs2_data, .d_imm, .d_rd,
        .d_alu_op, .d_use_imm, .d_mem_read, .d_mem_write, .d_branch, .d_branch_ne,
        .d_reg_write
    );

    rv_execute i_execute (
        .clk, .rst_n, .run,
        .d_valid, .d_pc, .d_rs1, .d_rs2, .d_rs1_data, .d_rs2_data, .d_imm, .d_rd,
        .d_alu_op, .d_use_imm, .d_mem_read, .d_mem_write, .d_branch, .d_branch_ne,
        .d_reg_write,
        .r_write, .r_rd, .r_data,
        .redirect, .redirect_pc,
        .e_valid, .e_rd, .e_alu_result, .e_mem_read, .e_reg_write, .e_load_data
    );

    rv_result i_result (
        .e_valid, .e_rd, .e_alu_result, .e_mem_read, .e_reg_write, .e_load_data,
        .r_write, .r_rd, .r_data,
        .wb_valid, .wb_rd, .wb_data
    );

endmodule

// File: hw/rv_result.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_result (
    input  logic                  e_valid,
    input  logic [`RV_REG_AW-1:0] e_rd,
    input  logic [`RV_XLEN-1:0]   e_alu_result,
    input  logic                  e_mem_read,
    input  logic                  e_reg_write,
    input  logic [`RV_XLEN-1:0]   e_load_data,
    output logic                  r_write,
    output logic [`RV_REG_AW-1:0] r_rd,
    output logic [`RV_XLEN-1:0]   r_data,
    output logic                  wb_valid,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data
);

    // Register bank write and forwarding source
    assign r_write = e_valid && e_reg_write && (e_rd != '0);
    assign r_rd    = e_rd;
    assign r_data  = e_mem_read ? e_load_data : e_alu_result;

    // Retire trace; loads update the bank but stay off the trace
    assign wb_valid = r_write && !e_mem_read;
    assign wb_rd    = r_rd;
    assign wb_data  = r_data;

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    d_valid,
    input  logic [`RV_XLEN-1:0]     d_pc,
    input  logic [`RV_REG_AW-1:0]   d_rs1,
    input  logic [`RV_REG_AW-1:0]   d_rs2,
    input  logic [`RV_XLEN-1:0]     d_rs1_data,
    input  logic [`RV_XLEN-1:0]     d_rs2_data,
    input  logic [`RV_XLEN-1:0]     d_imm,
    input  logic [`RV_REG_AW-1:0]   d_rd,
    input  logic [`RV_ALU_OP_W-1:0] d_alu_op,
    input  logic                    d_use_imm,
    input  logic                    d_mem_read,
    input  logic                    d_mem_write,
    input  logic                    d_branch,
    input  logic                    d_branch_ne,
    input  logic                    d_reg_write,
    input  logic                    r_write,
    input  logic [`RV_REG_AW-1:0]   r_rd,
    input  logic [`RV_XLEN-1:0]     r_data,
    output logic                    redirect,
    output logic [`RV_XLEN-1:0]     redirect_pc,
    output logic                    e_valid,
    output logic [`RV_REG_AW-1:0]   e_rd,
    output logic [`RV_XLEN-1:0]     e_alu_result,
    output logic                    e_mem_read,
    output logic                    e_reg_write,
    output logic [`RV_XLEN-1:0]     e_load_data
);

    logic [`RV_XLEN-1:0]    op_a;
    logic [`RV_XLEN-1:0]    fwd_b;
    logic [`RV_XLEN-1:0]    op_b;
    logic [`RV_XLEN-1:0]    alu_result;
    logic [`RV_DMEM_AW-1:0] dmem_addr;
    logic [`RV_XLEN-1:0]    dmem [0:`RV_DMEM_WORDS-1];

    // Forward from result; r_write is never set for x0
    assign op_a  = (r_write && r_rd == d_rs1) ? r_data : d_rs1_data;
    assign fwd_b = (r_write && r_rd == d_rs2) ? r_data : d_rs2_data;
    assign op_b  = d_use_imm ? d_imm : fwd_b;

    always_comb begin
        case (d_alu_op)
            `RV_ALU_ADD:   alu_result = op_a + op_b;
            `RV_ALU_SUB:   alu_result = op_a - op_b;
            `RV_ALU_AND:   alu_result = op_a & op_b;
            `RV_ALU_OR:    alu_result = op_a | op_b;
            `RV_ALU_XOR:   alu_result = op_a ^ op_b;
            `RV_ALU_SLT:   alu_result = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            `RV_ALU_SLL:   alu_result = op_a << op_b[4:0];
            `RV_ALU_SRL:   alu_result = op_a >> op_b[4:0];
            `RV_ALU_PASSB: alu_result = op_b;
            default:       alu_result = op_a + op_b;
        endcase
    end

    // BEQ takes on equal, BNE on not equal
    assign redirect    = d_valid && d_branch && ((op_a == fwd_b) != d_branch_ne);
    assign redirect_pc = d_pc + d_imm;

    assign dmem_addr = alu_result[`RV_DMEM_AW+1:2];

    // Word data memory, load data shows up in result
    always_ff @(posedge clk) begin
        if (d_valid && d_mem_write) begin
            dmem[dmem_addr] <= fwd_b;
        end
        if (d_valid && d_mem_read) begin
            e_load_data <= dmem[dmem_addr];
        end
        e_rd         <= d_rd;
        e_alu_result <= alu_result;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e_valid     <= 1'b0;
            e_mem_read  <= 1'b0;
            e_reg_write <= 1'b0;
        end else begin
            e_valid     <= run && d_valid;
            e_mem_read  <= d_mem_read;
            e_reg_write <= d_reg_write;
        end
    end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    run,
    input  logic                    f_valid,
    input  logic [`RV_XLEN-1:0]     f_pc,
    input  rv_pkg::rv_instr_u       f_instr,
    input  logic                    redirect,
    input  logic                    r_write,
    input  logic [`RV_REG_AW-1:0]   r_rd,
    input  logic [`RV_XLEN-1:0]     r_data,
    output logic                    d_valid,
    output logic [`RV_XLEN-1:0]     d_pc,
    output logic [`RV_REG_AW-1:0]   d_rs1,
    output logic [`RV_REG_AW-1:0]   d_rs2,
    output logic [`RV_XLEN-1:0]     d_rs1_data,
    output logic [`RV_XLEN-1:0]     d_rs2_data,
    output logic [`RV_XLEN-1:0]     d_imm,
    output logic [`RV_REG_AW-1:0]   d_rd,
    output logic [`RV_ALU_OP_W-1:0] d_alu_op,
    output logic                    d_use_imm,
    output logic                    d_mem_read,
    output logic                    d_mem_write,
    output logic                    d_branch,
    output logic                    d_branch_ne,
    output logic                    d_reg_write
);

    logic [`RV_XLEN-1:0]     regs [0:(1<<`RV_REG_AW)-1];
    logic [`RV_REG_AW-1:0]   rs1;
    logic [`RV_REG_AW-1:0]   rs2;
    logic [`RV_XLEN-1:0]     rs1_data;
    logic [`RV_XLEN-1:0]     rs2_data;
    logic [`RV_XLEN-1:0]     imm_i;
    logic [`RV_XLEN-1:0]     imm_s;
    logic [`RV_XLEN-1:0]     imm_b;
    logic [`RV_XLEN-1:0]     imm_u;
    logic [`RV_XLEN-1:0]     imm;
    logic [`RV_ALU_OP_W-1:0] alu_op;
    logic                    use_imm;
    logic                    mem_read;
    logic                    mem_write;
    logic                    branch;
    logic                    reg_write;

    assign rs1 = f_instr.r.rs1;
    assign rs2 = f_instr.s.rs2;

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{(`RV_XLEN-12){f_instr.r.funct7[6]}}, f_instr.r.funct7, f_instr.r.rs2};
    assign imm_s = {{(`RV_XLEN-12){f_instr.s.imm_hi[6]}}, f_instr.s.imm_hi, f_instr.s.imm_lo};
    assign imm_b = {{(`RV_XLEN-13){f_instr.s.imm_hi[6]}}, f_instr.s.imm_hi[6],
                    f_instr.s.imm_lo[0], f_instr.s.imm_hi[5:0], f_instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {f_instr.r.funct7, f_instr.r.rs2, f_instr.r.rs1, f_instr.r.funct3, 12'b0};

    always_comb begin
        alu_op    = `RV_ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        branch    = 1'b0;
        reg_write = 1'b0;
        case (f_instr.r.opcode)
            `RV_OP_LOAD: begin
                use_imm   = 1'b1;
                mem_read  = (f_instr.r.funct3 == 3'b010);   // LW only
                reg_write = mem_read;
            end
            `RV_OP_STORE: begin
                use_imm   = 1'b1;
                imm       = imm_s;
                mem_write = (f_instr.s.funct3 == 3'b010);   // SW only
            end
            `RV_OP_BRANCH: begin
                imm    = imm_b;
                branch = (f_instr.s.funct3[2:1] == 2'b00);  // BEQ, BNE
            end
            `RV_OP_IMM: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (f_instr.r.funct3)
                    3'b000:  alu_op = `RV_ALU_ADD;
                    3'b010:  alu_op = `RV_ALU_SLT;
                    3'b100:  alu_op = `RV_ALU_XOR;
                    3'b110:  alu_op = `RV_ALU_OR;
                    3'b111:  alu_op = `RV_ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            `RV_OP_REG: begin
                reg_write = 1'b1;
                case ({f_instr.r.funct7[5], f_instr.r.funct3})
                    4'b0000: alu_op = `RV_ALU_ADD;
                    4'b1000: alu_op = `RV_ALU_SUB;
                    4'b0001: alu_op = `RV_ALU_SLL;
                    4'b0010: alu_op = `RV_ALU_SLT;
                    4'b0100: alu_op = `RV_ALU_XOR;
                    4'b0101: alu_op = `RV_ALU_SRL;
                    4'b0110: alu_op = `RV_ALU_OR;
                    4'b0111: alu_op = `RV_ALU_AND;
                    default: reg_write = 1'b0;
                endcase
            end
            `RV_OP_LUI: begin
                alu_op    = `RV_ALU_PASSB;
                imm       = imm_u;
                use_imm   = 1'b1;
                reg_write = 1'b1;
            end
            default: begin
                reg_write = 1'b0;   // Anything else passes as a no-op
            end
        endcase
    end

    // Register bank, x0 reads zero, result stage write bypassed
    assign rs1_data = (rs1 == '0) ? '0 : (r_write && r_rd == rs1) ? r_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (r_write && r_rd == rs2) ? r_data : regs[rs2];

    always_ff @(posedge clk) begin
        if (r_write) begin
            regs[r_rd] <= r_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid     <= 1'b0;
            d_mem_read  <= 1'b0;
            d_mem_write <= 1'b0;
            d_branch    <= 1'b0;
            d_reg_write <= 1'b0;
        end else begin
            d_valid     <= run && f_valid && !redirect;
            d_mem_read  <= mem_read;
            d_mem_write <= mem_write;
            d_branch    <= branch;
            d_reg_write <= reg_write;
        end
    end

    always_ff @(posedge clk) begin
        d_pc        <= f_pc;
        d_rs1       <= rs1;
        d_rs2       <= rs2;
        d_rs1_data  <= rs1_data;
        d_rs2_data  <= rs2_data;
        d_imm       <= imm;
        d_rd        <= f_instr.r.rd;
        d_alu_op    <= alu_op;
        d_use_imm   <= use_imm;
        d_branch_ne <= f_instr.r.funct3[0];     // Set for BNE
    end

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic                   imem_we,
    input  logic [`RV_IMEM_AW-1:0] imem_addr,
    input  logic [`RV_XLEN-1:0]    imem_wdata,
    input  logic                   redirect,
    input  logic [`RV_XLEN-1:0]    redirect_pc,
    output logic                   f_valid,
    output logic [`RV_XLEN-1:0]    f_pc,
    output rv_pkg::rv_instr_u      f_instr
);

    logic [`RV_XLEN-1:0]    pc;
    logic [`RV_IMEM_AW-1:0] pc_word;
    rv_pkg::rv_instr_u      imem [0:`RV_IMEM_WORDS-1];

    assign pc_word = pc[`RV_IMEM_AW+1:2];   // Word index, byte offset dropped

    // Program counter and valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= '0;
            f_valid <= 1'b0;
        end else if (!run) begin
            pc      <= '0;                  // Halted, restart from 0
            f_valid <= 1'b0;
        end else begin
            pc      <= redirect ? redirect_pc : pc + 'd4;
            f_valid <= !redirect;           // Word read now is on the wrong path
        end
    end

    // Load port writes, fetch reads the same array
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
        f_instr <= imem[pc_word];
        f_pc    <= pc;
    end

endmodule

// File: hw/rv_pkg.sv
`include "rv_config.svh"

package rv_pkg;

    // One instruction word, seen as R-type or as S/B-type fields
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [`RV_REG_AW-1:0] rs2;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]            funct3;
            logic [`RV_REG_AW-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [6:0]            imm_hi;  // imm[11:5], or B offset 12 and 10:5
            logic [`RV_REG_AW-1:0] rs2;
            logic [`RV_REG_AW-1:0] rs1;
            logic [2:0]            funct3;
            logic [4:0]            imm_lo;  // imm[4:0], or B offset 4:1 and 11
            logic [6:0]            opcode;
        } s;
    } rv_instr_u;

endpackage

// File: hw/rv_config.svh
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Datapath and register file
`define RV_XLEN         32
`define RV_REG_AW       5

// Memory depths in words, word address widths
`define RV_IMEM_WORDS   256
`define RV_DMEM_WORDS   256
`define RV_IMEM_AW      8
`define RV_DMEM_AW      8

// Major opcodes
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LUI       7'b0110111

// ALU operation codes
`define RV_ALU_OP_W     4
`define RV_ALU_ADD      4'd0
`define RV_ALU_SUB      4'd1
`define RV_ALU_AND      4'd2
`define RV_ALU_OR       4'd3
`define RV_ALU_XOR      4'd4
`define RV_ALU_SLT      4'd5
`define RV_ALU_SLL      4'd6
`define RV_ALU_SRL      4'd7
`define RV_ALU_PASSB    4'd8    // Operand b straight through, for LUI

`endif
